// File: common/msp430_per_pkg.sv
package msp430_per_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int PER_AW = 14;                    // Word address
  localparam int PER_DW = 16;                    // Data bus
  localparam int AXI_AW = 16;                    // AXI byte address
  localparam int IRQ_NR = 14;                    // Maskable vectors

  // Vector map
  localparam int IRQ_VEC_PORT1 = 2;
  localparam int IRQ_VEC_PORT2 = 3;
  localparam int IRQ_VEC_TA0   = 9;

  // ----------------------------------------
  // Address map, byte addresses
  // ----------------------------------------
  localparam int unsigned P1_BASE      = 'h0020;
  localparam int unsigned P2_BASE      = 'h0028;
  localparam int unsigned GPIO_IN_OFS  = 0;      // Read only
  localparam int unsigned GPIO_OUT_OFS = 1;
  localparam int unsigned GPIO_DIR_OFS = 2;
  localparam int unsigned GPIO_IFG_OFS = 3;
  localparam int unsigned GPIO_IES_OFS = 4;
  localparam int unsigned GPIO_IE_OFS  = 5;
  localparam int unsigned GPIO_SEL_OFS = 6;

  localparam int unsigned TACTL_ADDR   = 'h0160;
  localparam int unsigned TACCTL0_ADDR = 'h0162;
  localparam int unsigned TAR_ADDR     = 'h0170;
  localparam int unsigned TACCR0_ADDR  = 'h0172;

  localparam int unsigned TEMP16_BASE = 'h0190;
  localparam int          TEMP16_NR   = 4;       // Word registers

  // Timer field positions
  localparam int TACTL_MC_BIT     = 4;           // Up mode
  localparam int TACTL_CLR_BIT    = 2;           // Self clearing
  localparam int TACTL_ID_LSB     = 6;           // Divider, 2 bits
  localparam int TACCTL_CCIE_BIT  = 4;
  localparam int TACCTL_CCIFG_BIT = 0;

  // ----------------------------------------
  // Bus and pin types
  // ----------------------------------------
  typedef struct packed {
    logic [PER_AW-1:0] addr;                     // Word address
    logic              en;                       // Cycle valid
    logic [1:0]        we;                       // Byte strobes, zero is read
    logic [PER_DW-1:0] din;                      // Write data
  } per_req_t;

  typedef struct packed {
    logic [7:0] dout;
    logic [7:0] dout_en;
    logic [7:0] sel;
  } gpio_pins_t;

  // Decode helpers shared by all peripherals
  function automatic logic per_hit(per_req_t req, int unsigned byte_addr);
    return req.en && (req.addr == byte_addr[PER_AW:1]);
  endfunction

  function automatic logic per_wr_byte(per_req_t req, int unsigned byte_addr);
    return per_hit(req, byte_addr) && req.we[byte_addr[0]];   // Lane from addr bit 0
  endfunction

  function automatic logic [7:0] per_din_byte(per_req_t req, int unsigned byte_addr);
    return req.din[8*byte_addr[0] +: 8];
  endfunction

  function automatic logic [PER_DW-1:0] per_rd_byte(per_req_t req, int unsigned byte_addr,
                                                   logic [7:0] val);
    if (per_hit(req, byte_addr) && (req.we == 2'b00))
      return PER_DW'(val) << (8*byte_addr[0]);                // Into own lane
    return '0;
  endfunction

  function automatic logic [PER_DW-1:0] per_rd_word(per_req_t req, int unsigned byte_addr,
                                                   logic [PER_DW-1:0] val);
    if (per_hit(req, byte_addr) && (req.we == 2'b00))
      return val;
    return '0;
  endfunction

endpackage

// File: hdl/per_axil_bridge.sv
`timescale 1ns/100ps

module per_axil_bridge import msp430_per_pkg::*; (
  input  logic                mclk,
  input  logic                arst_n,
  // Write address and data
  input  logic [AXI_AW-1:0]   awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [PER_DW-1:0]   wdata,
  input  logic [PER_DW/8-1:0] wstrb,
  input  logic                wvalid,
  output logic                wready,
  // Write response
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  // Read
  input  logic [AXI_AW-1:0]   araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [PER_DW-1:0]   rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  // Peripheral bus
  output per_req_t            per_req,
  input  logic [PER_DW-1:0]   dout_p1,
  input  logic [PER_DW-1:0]   dout_p2,
  input  logic [PER_DW-1:0]   dout_ta,
  input  logic [PER_DW-1:0]   dout_temp
);

  typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_RESP} state_t;

  state_t            state;
  logic              ready_q;                    // Low in reset and while busy
  logic              is_rd;                      // Current transfer is a read
  logic              rd_go;
  logic              wr_go;
  logic [PER_DW-1:0] dout_or;

  assign dout_or = dout_p1 | dout_p2 | dout_ta | dout_temp;   // Unselected return zero

  assign rd_go   = ready_q && arvalid;
  assign wr_go   = ready_q && awvalid && wvalid && !arvalid;  // Read wins
  assign arready = ready_q;
  assign awready = wr_go;                        // AW and W taken together
  assign wready  = wr_go;
  assign bresp   = 2'b00;                        // OKAY
  assign rresp   = 2'b00;

  // ----------------------------------------
  // Transfer FSM
  // ----------------------------------------
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      ready_q <= 1'b0;
      is_rd   <= 1'b0;
      per_req <= '0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          ready_q <= 1'b1;
          if (rd_go) begin
            per_req <= '{addr: araddr[PER_AW:1], en: 1'b1, we: 2'b00, din: '0};
            is_rd   <= 1'b1;
            ready_q <= 1'b0;
            state   <= ST_BUS;
          end else if (wr_go) begin
            per_req <= '{addr: awaddr[PER_AW:1], en: 1'b1, we: wstrb, din: wdata};
            is_rd   <= 1'b0;
            ready_q <= 1'b0;
            state   <= ST_BUS;
          end
        end
        ST_BUS: begin                            // Single request cycle
          per_req.en <= 1'b0;
          per_req.we <= 2'b00;
          state      <= ST_RESP;
        end
        ST_RESP: begin
          if (!bvalid && !rvalid) begin          // Raise one cycle after the bus cycle
            bvalid <= !is_rd;
            rvalid <= is_rd;
          end else if ((bvalid && bready) || (rvalid && rready)) begin
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            ready_q <= 1'b1;
            state   <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Read data sampled during the bus cycle and held through back-pressure
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n)
      rdata <= '0;
    else if (state == ST_BUS && is_rd)
      rdata <= dout_or;
  end

endmodule

// File: gpio/gpio_port.sv
`timescale 1ns/100ps

module gpio_port import msp430_per_pkg::*; #(
  parameter int unsigned BASE_ADDR = P1_BASE     // Byte address of PxIN
) (
  input  logic              mclk,
  input  logic              arst_n,
  input  per_req_t          per_req,
  output logic [PER_DW-1:0] per_dout,
  input  logic [7:0]        din,                 // Asynchronous pins
  output gpio_pins_t        pins,
  output logic              irq
);

  logic [7:0] pout;
  logic [7:0] pdir;
  logic [7:0] pifg;
  logic [7:0] pies;                              // 1 selects falling edge
  logic [7:0] pie;
  logic [7:0] psel;
  logic [7:0] din_s1;
  logic [7:0] din_s2;                            // Synchronized, read as PxIN
  logic [7:0] din_d;
  logic [7:0] rise;
  logic [7:0] fall;
  logic [7:0] edge_set;

  // ----------------------------------------
  // Input sync and edge detect
  // ----------------------------------------
  assign rise     = din_s2 & ~din_d;
  assign fall     = ~din_s2 & din_d;
  assign edge_set = (rise & ~pies) | (fall & pies);

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      din_s1 <= '0;
      din_s2 <= '0;
      din_d  <= '0;
      pout   <= '0;
      pdir   <= '0;
      pifg   <= '0;
      pies   <= '0;
      pie    <= '0;
      psel   <= '0;
    end else begin
      din_s1 <= din;
      din_s2 <= din_s1;
      din_d  <= din_s2;
      if (per_wr_byte(per_req, BASE_ADDR + GPIO_OUT_OFS))
        pout <= per_din_byte(per_req, BASE_ADDR + GPIO_OUT_OFS);
      if (per_wr_byte(per_req, BASE_ADDR + GPIO_DIR_OFS))
        pdir <= per_din_byte(per_req, BASE_ADDR + GPIO_DIR_OFS);
      if (per_wr_byte(per_req, BASE_ADDR + GPIO_IES_OFS))
        pies <= per_din_byte(per_req, BASE_ADDR + GPIO_IES_OFS);
      if (per_wr_byte(per_req, BASE_ADDR + GPIO_IE_OFS))
        pie <= per_din_byte(per_req, BASE_ADDR + GPIO_IE_OFS);
      if (per_wr_byte(per_req, BASE_ADDR + GPIO_SEL_OFS))
        psel <= per_din_byte(per_req, BASE_ADDR + GPIO_SEL_OFS);
      // New edges win over a software clear in the same cycle
      if (per_wr_byte(per_req, BASE_ADDR + GPIO_IFG_OFS))
        pifg <= per_din_byte(per_req, BASE_ADDR + GPIO_IFG_OFS) | edge_set;
      else
        pifg <= pifg | edge_set;
    end
  end

  // ----------------------------------------
  // Read back, pins, interrupt
  // ----------------------------------------
  assign per_dout = per_rd_byte(per_req, BASE_ADDR + GPIO_IN_OFS,  din_s2) |
                    per_rd_byte(per_req, BASE_ADDR + GPIO_OUT_OFS, pout)   |
                    per_rd_byte(per_req, BASE_ADDR + GPIO_DIR_OFS, pdir)   |
                    per_rd_byte(per_req, BASE_ADDR + GPIO_IFG_OFS, pifg)   |
                    per_rd_byte(per_req, BASE_ADDR + GPIO_IES_OFS, pies)   |
                    per_rd_byte(per_req, BASE_ADDR + GPIO_IE_OFS,  pie)    |
                    per_rd_byte(per_req, BASE_ADDR + GPIO_SEL_OFS, psel);

  assign pins = '{dout: pout, dout_en: pdir, sel: psel};

  assign irq = |(pifg & pie);                    // Same cycle as flag

endmodule

// File: timer_a/timer_a.sv
`timescale 1ns/100ps

module timer_a import msp430_per_pkg::*; (
  input  logic              mclk,
  input  logic              arst_n,
  input  per_req_t          per_req,
  output logic [PER_DW-1:0] per_dout,
  input  logic              irq_acc,             // CCR0 vector taken
  output logic              irq_ta0
);

  logic [1:0]        ta_id;                      // Input divider select
  logic              ta_mc;                      // Up mode
  logic              ccie;
  logic              ccifg;
  logic [PER_DW-1:0] taccr0;
  logic [PER_DW-1:0] tar;
  logic [2:0]        div_cnt;
  logic [2:0]        div_max;
  logic [7:0]        tactl_din;
  logic [7:0]        tacctl_din;
  logic              tactl_wr;
  logic              tacctl_wr;
  logic              tar_wr;
  logic              ta_clr;
  logic              tick;
  logic              wrap;
  logic [PER_DW-1:0] tactl_rd;
  logic [PER_DW-1:0] tacctl_rd;

  // Control fields sit in the low byte
  assign tactl_din  = per_din_byte(per_req, TACTL_ADDR);
  assign tacctl_din = per_din_byte(per_req, TACCTL0_ADDR);
  assign tactl_wr   = per_wr_byte(per_req, TACTL_ADDR);
  assign tacctl_wr  = per_wr_byte(per_req, TACCTL0_ADDR);
  assign tar_wr     = per_wr_byte(per_req, TAR_ADDR) | per_wr_byte(per_req, TAR_ADDR + 1);
  assign ta_clr     = tactl_wr && tactl_din[TACTL_CLR_BIT];

  // ----------------------------------------
  // Divider and wrap
  // ----------------------------------------
  assign div_max = 3'((4'd1 << ta_id) - 4'd1);   // 0, 1, 3 or 7
  assign tick    = ta_mc && ((div_cnt & div_max) == div_max);
  assign wrap    = tick && (tar == taccr0);

  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      ta_id   <= '0;
      ta_mc   <= 1'b0;
      ccie    <= 1'b0;
      ccifg   <= 1'b0;
      taccr0  <= '0;
      tar     <= '0;
      div_cnt <= '0;
    end else begin
      if (tactl_wr) begin
        ta_id <= tactl_din[TACTL_ID_LSB +: 2];
        ta_mc <= tactl_din[TACTL_MC_BIT];
      end
      if (tacctl_wr)
        ccie <= tacctl_din[TACCTL_CCIE_BIT];
      if (wrap)                                  // Set has priority
        ccifg <= 1'b1;
      else if (irq_acc)
        ccifg <= 1'b0;
      else if (tacctl_wr)
        ccifg <= tacctl_din[TACCTL_CCIFG_BIT];
      for (int b = 0; b < 2; b++) begin
        if (per_wr_byte(per_req, TACCR0_ADDR + b))
          taccr0[8*b +: 8] <= per_din_byte(per_req, TACCR0_ADDR + b);
      end
      if (ta_clr)
        div_cnt <= '0;
      else if (ta_mc)
        div_cnt <= div_cnt + 3'd1;
      if (ta_clr) begin
        tar <= '0;
      end else if (tar_wr) begin
        for (int b = 0; b < 2; b++) begin
          if (per_wr_byte(per_req, TAR_ADDR + b))
            tar[8*b +: 8] <= per_din_byte(per_req, TAR_ADDR + b);
        end
      end else if (tick) begin
        tar <= wrap ? '0 : tar + 16'd1;          // Up to TACCR0 then 0
      end
    end
  end

  // ----------------------------------------
  // Read back
  // ----------------------------------------
  always_comb begin
    tactl_rd                           = '0;     // CLR always reads 0
    tactl_rd[TACTL_ID_LSB +: 2]        = ta_id;
    tactl_rd[TACTL_MC_BIT]             = ta_mc;
    tacctl_rd                          = '0;
    tacctl_rd[TACCTL_CCIE_BIT]         = ccie;
    tacctl_rd[TACCTL_CCIFG_BIT]        = ccifg;
  end

  assign per_dout = per_rd_word(per_req, TACTL_ADDR,   tactl_rd)  |
                    per_rd_word(per_req, TACCTL0_ADDR, tacctl_rd) |
                    per_rd_word(per_req, TAR_ADDR,     tar)       |
                    per_rd_word(per_req, TACCR0_ADDR,  taccr0);

  assign irq_ta0 = ccifg & ccie;

endmodule

// File: hdl/template16.sv
`timescale 1ns/100ps

module template16 import msp430_per_pkg::*; (
  input  logic              mclk,
  input  logic              arst_n,
  input  per_req_t          per_req,
  output logic [PER_DW-1:0] per_dout
);

  logic [PER_DW-1:0] cntrl [TEMP16_NR];          // CNTRL1..4

  // Byte-wise writes, high byte at odd address
  always_ff @(posedge mclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < TEMP16_NR; i++)
        cntrl[i] <= '0;
    end else begin
      for (int i = 0; i < TEMP16_NR; i++) begin
        for (int b = 0; b < 2; b++) begin
          if (per_wr_byte(per_req, TEMP16_BASE + 2*i + b))
            cntrl[i][8*b +: 8] <= per_din_byte(per_req, TEMP16_BASE + 2*i + b);
        end
      end
    end
  end

  // Read mux, zero when not addressed
  always_comb begin
    per_dout = '0;
    for (int i = 0; i < TEMP16_NR; i++)
      per_dout = per_dout | per_rd_word(per_req, TEMP16_BASE + 2*i, cntrl[i]);
  end

endmodule

// File: hdl/msp430_periph_top.sv
`timescale 1ns/100ps

module msp430_periph_top import msp430_per_pkg::*; (
  input  logic                mclk,
  input  logic                arst_n,
  // AXI4-Lite slave
  input  logic [AXI_AW-1:0]   awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [PER_DW-1:0]   wdata,
  input  logic [PER_DW/8-1:0] wstrb,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [AXI_AW-1:0]   araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [PER_DW-1:0]   rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  // Ports
  input  logic [7:0]          p1_din,
  input  logic [7:0]          p2_din,
  output gpio_pins_t          p1_pins,
  output gpio_pins_t          p2_pins,
  // Interrupts
  input  logic [IRQ_NR-1:0]   irq,               // External requests
  input  logic [IRQ_NR-1:0]   irq_acc,           // One-hot acceptance
  output logic [IRQ_NR-1:0]   irq_out
);

  per_req_t          per_req;
  logic [PER_DW-1:0] dout_p1;
  logic [PER_DW-1:0] dout_p2;
  logic [PER_DW-1:0] dout_ta;
  logic [PER_DW-1:0] dout_temp;
  logic              irq_port1;
  logic              irq_port2;
  logic              irq_ta0;

  // AXI ports, per_req and read data all share names with the bridge
  per_axil_bridge per_axil_bridge_inst (.*);

  // ----------------------------------------
  // Peripherals
  // ----------------------------------------
  gpio_port #(.BASE_ADDR(P1_BASE)) port1_inst (
    .mclk     (mclk),
    .arst_n   (arst_n),
    .per_req  (per_req),
    .per_dout (dout_p1),
    .din      (p1_din),
    .pins     (p1_pins),
    .irq      (irq_port1)
  );

  gpio_port #(.BASE_ADDR(P2_BASE)) port2_inst (
    .mclk     (mclk),
    .arst_n   (arst_n),
    .per_req  (per_req),
    .per_dout (dout_p2),
    .din      (p2_din),
    .pins     (p2_pins),
    .irq      (irq_port2)
  );

  timer_a timer_a_inst (
    .mclk     (mclk),
    .arst_n   (arst_n),
    .per_req  (per_req),
    .per_dout (dout_ta),
    .irq_acc  (irq_acc[IRQ_VEC_TA0]),            // Clears CCIFG
    .irq_ta0  (irq_ta0)
  );

  template16 template16_inst (
    .mclk     (mclk),
    .arst_n   (arst_n),
    .per_req  (per_req),
    .per_dout (dout_temp)
  );

  // ----------------------------------------
  // Interrupt vector map
  // ----------------------------------------
  assign irq_out = irq                                     |
                   (IRQ_NR'(irq_port1) << IRQ_VEC_PORT1)   |  // Vector 2
                   (IRQ_NR'(irq_port2) << IRQ_VEC_PORT2)   |  // Vector 3
                   (IRQ_NR'(irq_ta0)   << IRQ_VEC_TA0);       // Vector 9

endmodule

// File: bench/tb_msp430_periph.sv
`timescale 1ns/100ps

module tb_msp430_periph import msp430_per_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 5;
  localparam int HS_LIMIT   = 50;                // Cycles allowed per handshake
  localparam int WDOG_STEP  = 100;               // Cycles per table entry

  typedef enum logic [3:0] {
    OP_WR, OP_RD, OP_PIN, OP_PINS, OP_IRQ, OP_WAIT_IRQ, OP_ACC, OP_EXT, OP_TAR_MAX, OP_BACKPR
  } op_t;

  typedef struct packed {
    op_t         op;
    logic [15:0] addr;                           // Byte address, port or vector
    logic [31:0] data;                           // Write data, pin value or count
    logic [1:0]  strb;
    logic [31:0] exp;
  } step_t;

  logic                mclk;
  logic                arst_n;
  logic [AXI_AW-1:0]   awaddr;
  logic                awvalid;
  logic                awready;
  logic [PER_DW-1:0]   wdata;
  logic [PER_DW/8-1:0] wstrb;
  logic                wvalid;
  logic                wready;
  logic [1:0]          bresp;
  logic                bvalid;
  logic                bready;
  logic [AXI_AW-1:0]   araddr;
  logic                arvalid;
  logic                arready;
  logic [PER_DW-1:0]   rdata;
  logic [1:0]          rresp;
  logic                rvalid;
  logic                rready;
  logic [7:0]          p1_din;
  logic [7:0]          p2_din;
  gpio_pins_t          p1_pins;
  gpio_pins_t          p2_pins;
  logic [IRQ_NR-1:0]   irq;
  logic [IRQ_NR-1:0]   irq_acc;
  logic [IRQ_NR-1:0]   irq_out;

  step_t       steps[$];
  string       names[$];
  string       cur_name;
  int          n_steps = 0;
  int          step_err;
  int          n_pass = 0;
  int          n_fail = 0;
  logic [31:0] rng_state = 32'h1eb9a08a;

  msp430_periph_top msp430_periph_top_inst (.*);

  initial begin
    mclk = 1'b0;
    forever #(CLK_PERIOD/2) mclk = ~mclk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [15:0] rand16();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;   // LCG
    return rng_state[31:16];
  endfunction

  function automatic logic [15:0] p1_reg(int unsigned ofs);
    return 16'(P1_BASE + ofs);
  endfunction

  function automatic logic [15:0] p2_reg(int unsigned ofs);
    return 16'(P2_BASE + ofs);
  endfunction

  function automatic logic [15:0] tmp_reg(int unsigned idx);
    return 16'(TEMP16_BASE + 2*idx);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, got %h", name, exp, act);
      step_err++;
    end
  endtask

  task automatic add_step(input string name, input op_t op, input logic [15:0] addr,
                          input logic [31:0] data, input logic [1:0] strb,
                          input logic [31:0] exp);
    names.push_back(name);
    steps.push_back('{op: op, addr: addr, data: data, strb: strb, exp: exp});
  endtask

  // ----------------------------------------
  // AXI4-Lite host
  // ----------------------------------------
  task automatic axi_write(input logic [15:0] addr, input logic [15:0] data,
                           input logic [1:0] strb);
    int n;
    @(negedge mclk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n = 0;
    #1;                                          // Ready settled by mid low phase
    while (!awready && n < HS_LIMIT) begin
      @(negedge mclk);
      #1;
      n++;
    end
    @(negedge mclk);                             // Handshake was on the edge before
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (n >= HS_LIMIT) begin
      $display("%s: write to %h was never accepted", cur_name, addr);
      step_err++;
      bready = 1'b0;
      return;
    end
    n = 0;
    #1;
    while (!bvalid && n < HS_LIMIT) begin
      @(negedge mclk);
      #1;
      n++;
    end
    if (n >= HS_LIMIT) begin
      $display("%s: no write response for %h", cur_name, addr);
      step_err++;
    end else begin
      check_value({cur_name, "_bresp"}, 32'd0, {30'b0, bresp});   // OKAY
    end
    @(negedge mclk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [15:0] addr, output logic [15:0] data);
    int n;
    data = '0;
    @(negedge mclk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    n = 0;
    #1;
    while (!arready && n < HS_LIMIT) begin
      @(negedge mclk);
      #1;
      n++;
    end
    @(negedge mclk);
    arvalid = 1'b0;
    if (n >= HS_LIMIT) begin
      $display("%s: read of %h was never accepted", cur_name, addr);
      step_err++;
      rready = 1'b0;
      return;
    end
    n = 0;
    #1;
    while (!rvalid && n < HS_LIMIT) begin
      @(negedge mclk);
      #1;
      n++;
    end
    if (n >= HS_LIMIT) begin
      $display("%s: no read data for %h", cur_name, addr);
      step_err++;
    end else begin
      check_value({cur_name, "_rresp"}, 32'd0, {30'b0, rresp});
    end
    data = rdata;
    @(negedge mclk);
    rready = 1'b0;
  endtask

  // Read held back by rready low while a write waits at the slave
  task automatic run_backpressure(input logic [15:0] addr, input logic [31:0] exp);
    logic [15:0] held;
    bit          stable;
    int          n;
    @(negedge mclk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    n = 0;
    #1;
    while (!arready && n < HS_LIMIT) begin
      @(negedge mclk);
      #1;
      n++;
    end
    @(negedge mclk);
    arvalid = 1'b0;
    n = 0;
    #1;
    while (!rvalid && n < HS_LIMIT) begin
      @(negedge mclk);
      #1;
      n++;
    end
    if (n >= HS_LIMIT) begin
      $display("%s: read response never arrived", cur_name);
      step_err++;
    end
    held    = rdata;
    awaddr  = tmp_reg(3);                        // Must not land
    wdata   = 16'hdead;
    wstrb   = 2'b11;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    stable  = 1'b1;
    repeat (10) begin
      @(negedge mclk);
      #1;
      if (!rvalid || rdata !== held || awready || wready || arready)
        stable = 1'b0;
    end
    @(negedge mclk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    rready  = 1'b1;
    @(negedge mclk);
    rready  = 1'b0;
    check_value(cur_name, exp, {16'h0, held});
    check_value({cur_name, "_stable"}, 32'd1, {31'b0, stable});
  endtask

  // ----------------------------------------
  // Table driven steps
  // ----------------------------------------
  task automatic run_step(input step_t s);
    logic [15:0] v;
    logic [15:0] worst;
    logic        got;
    int          n;
    case (s.op)
      OP_WR: axi_write(s.addr, s.data[15:0], s.strb);
      OP_RD: begin
        axi_read(s.addr, v);
        check_value(cur_name, s.exp, {16'h0, v});
      end
      OP_PIN: begin
        @(negedge mclk);
        if (s.addr == 16'd1)
          p1_din = s.data[7:0];
        else
          p2_din = s.data[7:0];
        repeat (5) @(negedge mclk);              // Sync plus edge detect
      end
      OP_PINS: begin
        @(negedge mclk);
        check_value(cur_name, s.exp, {8'h0, (s.addr == 16'd1) ? p1_pins : p2_pins});
      end
      OP_IRQ: begin
        @(negedge mclk);
        check_value(cur_name, s.exp, {31'b0, irq_out[s.addr[3:0]]});
      end
      OP_WAIT_IRQ: begin
        got = 1'b0;
        n   = 0;
        while (!got && n < s.data) begin
          @(negedge mclk);
          got = irq_out[s.addr[3:0]];
          n++;
        end
        check_value(cur_name, s.exp, {31'b0, got});
      end
      OP_ACC: begin                              // One cycle pulse
        @(negedge mclk);
        irq_acc[s.addr[3:0]] = 1'b1;
        @(negedge mclk);
        irq_acc = '0;
      end
      OP_EXT: begin
        @(negedge mclk);
        irq = s.data[IRQ_NR-1:0];
      end
      OP_TAR_MAX: begin
        worst = '0;
        repeat (s.data) begin
          axi_read(s.addr, v);
          if (v > worst)
            worst = v;
        end
        if ({16'h0, worst} > s.exp)
          check_value(cur_name, s.exp, {16'h0, worst});
      end
      OP_BACKPR: run_backpressure(s.addr, s.exp);
      default: begin
        $display("%s: unknown table operation", cur_name);
        step_err++;
      end
    endcase
  endtask

  task automatic build_table();
    logic [15:0] tmp_val [TEMP16_NR];
    logic [15:0] v;
    logic [31:0] ta_run;
    logic [31:0] ccie;
    ta_run = 32'((1 << TACTL_MC_BIT) | (1 << TACTL_CLR_BIT));
    ccie   = 32'(1 << TACCTL_CCIE_BIT);
    // Template registers
    for (int i = 0; i < TEMP16_NR; i++) begin
      tmp_val[i] = rand16();
      add_step($sformatf("tmpl_wr%0d", i), OP_WR, tmp_reg(i), {16'h0, tmp_val[i]}, 2'b11, 0);
    end
    for (int i = 0; i < TEMP16_NR; i++)
      add_step($sformatf("tmpl_rd%0d", i), OP_RD, tmp_reg(i), 0, 2'b00, {16'h0, tmp_val[i]});
    v = rand16();
    add_step("tmpl_hi_wr", OP_WR, tmp_reg(1), {16'h0, v}, 2'b10, 0);
    tmp_val[1] = {v[15:8], tmp_val[1][7:0]};     // Low byte kept
    add_step("tmpl_hi_rd", OP_RD, tmp_reg(1), 0, 2'b00, {16'h0, tmp_val[1]});
    // GPIO registers in odd and even lanes
    add_step("p1_out_wr", OP_WR, p1_reg(GPIO_OUT_OFS), 32'h0000_a500, 2'b10, 0);
    add_step("p1_dir_wr", OP_WR, p1_reg(GPIO_DIR_OFS), 32'h0000_5af0, 2'b01, 0);
    add_step("p1_sel_wr", OP_WR, p1_reg(GPIO_SEL_OFS), 32'h0000_0033, 2'b01, 0);
    add_step("p1_out_rd", OP_RD, p1_reg(GPIO_OUT_OFS), 0, 2'b00, 32'h0000_a500);
    add_step("p1_dir_rd", OP_RD, p1_reg(GPIO_DIR_OFS), 0, 2'b00, 32'h0000_00f0);
    add_step("p1_sel_rd", OP_RD, p1_reg(GPIO_SEL_OFS), 0, 2'b00, 32'h0000_0033);
    add_step("p1_pins", OP_PINS, 16'd1, 0, 2'b00, 32'h00a5_f033);
    add_step("p2_pins_idle", OP_PINS, 16'd2, 0, 2'b00, 32'h0);
    // Input and unmapped reads
    add_step("p2_din_set", OP_PIN, 16'd2, 32'h3c, 2'b00, 0);
    add_step("p2_in_rd", OP_RD, p2_reg(GPIO_IN_OFS), 0, 2'b00, 32'h0000_003c);
    add_step("unmapped_rd0", OP_RD, 16'h0100, 0, 2'b00, 32'h0);
    add_step("unmapped_rd1", OP_RD, 16'h0198, 0, 2'b00, 32'h0);
    // Port 1 rising edge
    add_step("p1_ie_wr", OP_WR, p1_reg(GPIO_IE_OFS), 32'h0000_0100, 2'b10, 0);
    add_step("p1_irq_idle", OP_IRQ, 16'(IRQ_VEC_PORT1), 0, 2'b00, 32'd0);
    add_step("p1_din_rise", OP_PIN, 16'd1, 32'h01, 2'b00, 0);
    add_step("p1_irq_set", OP_IRQ, 16'(IRQ_VEC_PORT1), 0, 2'b00, 32'd1);
    add_step("p1_ifg_rd", OP_RD, p1_reg(GPIO_IFG_OFS), 0, 2'b00, 32'h0000_01f0);
    add_step("p1_ifg_clr", OP_WR, p1_reg(GPIO_IFG_OFS), 32'h0, 2'b10, 0);
    add_step("p1_irq_clr", OP_IRQ, 16'(IRQ_VEC_PORT1), 0, 2'b00, 32'd0);
    add_step("p1_ifg_rd_clr", OP_RD, p1_reg(GPIO_IFG_OFS), 0, 2'b00, 32'h0000_00f0);
    // Port 2 falling edge after clearing the earlier rising-edge flags
    add_step("p2_ies_wr", OP_WR, p2_reg(GPIO_IES_OFS), 32'h0000_0004, 2'b01, 0);
    add_step("p2_ifg_clr", OP_WR, p2_reg(GPIO_IFG_OFS), 32'h0, 2'b10, 0);
    add_step("p2_ie_wr", OP_WR, p2_reg(GPIO_IE_OFS), 32'h0000_0400, 2'b10, 0);
    add_step("p2_irq_idle", OP_IRQ, 16'(IRQ_VEC_PORT2), 0, 2'b00, 32'd0);
    add_step("p2_din_fall", OP_PIN, 16'd2, 32'h38, 2'b00, 0);
    add_step("p2_irq_set", OP_IRQ, 16'(IRQ_VEC_PORT2), 0, 2'b00, 32'd1);
    add_step("p2_ifg_rd", OP_RD, p2_reg(GPIO_IFG_OFS), 0, 2'b00, 32'h0000_0400);
    // Timer A up mode with a period of 10 cycles
    add_step("ta_ccr0_wr", OP_WR, 16'(TACCR0_ADDR), 32'd9, 2'b11, 0);
    add_step("ta_cctl_wr", OP_WR, 16'(TACCTL0_ADDR), ccie, 2'b11, 0);
    add_step("ta_start", OP_WR, 16'(TACTL_ADDR), ta_run, 2'b11, 0);
    add_step("ta_ctl_rd", OP_RD, 16'(TACTL_ADDR), 0, 2'b00, 32'(1 << TACTL_MC_BIT));
    add_step("ta_tar_max", OP_TAR_MAX, 16'(TAR_ADDR), 32'd12, 2'b00, 32'd9);
    add_step("ta_irq_first", OP_WAIT_IRQ, 16'(IRQ_VEC_TA0), 32'd40, 2'b00, 32'd1);
    add_step("ta_stop", OP_WR, 16'(TACTL_ADDR), 32'h0, 2'b11, 0);
    add_step("ta_acc_stopped", OP_ACC, 16'(IRQ_VEC_TA0), 0, 2'b00, 0);
    add_step("ta_irq_clr", OP_IRQ, 16'(IRQ_VEC_TA0), 0, 2'b00, 32'd0);
    add_step("ta_restart", OP_WR, 16'(TACTL_ADDR), ta_run, 2'b11, 0);
    add_step("ta_irq_rise", OP_WAIT_IRQ, 16'(IRQ_VEC_TA0), 32'd40, 2'b00, 32'd1);
    add_step("ta_acc", OP_ACC, 16'(IRQ_VEC_TA0), 0, 2'b00, 0);
    add_step("ta_ccifg_rd", OP_RD, 16'(TACCTL0_ADDR), 0, 2'b00, ccie);   // Before next wrap
    add_step("ta_irq_again", OP_WAIT_IRQ, 16'(IRQ_VEC_TA0), 32'd40, 2'b00, 32'd1);
    // External request and back-pressure
    add_step("ext_irq_set", OP_EXT, 16'd0, 32'(1 << 12), 2'b00, 0);
    add_step("ext_irq_seen", OP_IRQ, 16'd12, 0, 2'b00, 32'd1);
    add_step("ext_irq_clr", OP_EXT, 16'd0, 32'h0, 2'b00, 0);
    add_step("ext_irq_gone", OP_IRQ, 16'd12, 0, 2'b00, 32'd0);
    add_step("rd_backpressure", OP_BACKPR, tmp_reg(2), 0, 2'b00, {16'h0, tmp_val[2]});
    add_step("tmpl_rd3_after", OP_RD, tmp_reg(3), 0, 2'b00, {16'h0, tmp_val[3]});
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    p1_din  = '0;
    p2_din  = '0;
    irq     = '0;
    irq_acc = '0;
    build_table();
    n_steps = steps.size();
    repeat (RST_CYCLES) @(posedge mclk);
    @(negedge mclk);
    arst_n = 1'b1;
    foreach (steps[i]) begin
      cur_name = names[i];
      step_err = 0;
      run_step(steps[i]);
      if (step_err == 0) begin
        n_pass++;
        $display("ok   %s", cur_name);
      end else begin
        n_fail++;
        $display("FAIL %s", cur_name);
      end
    end
    $display("%0d tests, %0d passed, %0d failed", n_steps, n_pass, n_fail);
    if (n_fail == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    wait (n_steps != 0);
    repeat (n_steps * WDOG_STEP) @(posedge mclk);
    $display("Watchdog expired, run did not finish within %0d cycles", n_steps * WDOG_STEP);
    $display("Test failed");
    $finish;
  end

endmodule

// File: project.f
common/msp430_per_pkg.sv
hdl/per_axil_bridge.sv
gpio/gpio_port.sv
timer_a/timer_a.sv
hdl/template16.sv
hdl/msp430_periph_top.sv
bench/tb_msp430_periph.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_msp430_periph
LOG=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  --top-module "$TOP" -f project.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation run clean"
exit 0
